/* design/dep_check_top.sv */
`timescale 1ns/1ns

module dep_check_top
    import dep_pkg::*;
#(
    parameter int LANES = 8
) (
    input  logic                                        w_fire01,
    input  logic                                        rstn,
    input  logic                                        i_drive,
    input  logic [LANES-1:0][UOP_W-1:0]                 i_uops,
    output logic                                        o_free,
    output logic                                        o_drive,
    input  logic                                        i_free_next,
    output logic [2*LANES-1:0][UOP_W-1:0]               o_uops,
    output logic [2*LANES-1:0][$clog2(2*LANES)-1:0]     o_dep_l,
    output logic [2*LANES-1:0][$clog2(2*LANES)-1:0]     o_dep_r
);

    localparam int WINDOW = 2 * LANES;

    logic                           gather_drive;
    logic [WINDOW-1:0][UOP_W-1:0]   gather_uops;
    logic                           matrix_free;
    logic                           matrix_drive;
    logic [WINDOW-1:0][UOP_W-1:0]   matrix_uops;
    logic [WINDOW-1:0][WINDOW-1:0]  match_l;
    logic [WINDOW-1:0][WINDOW-1:0]  match_r;
    logic                           encode_free;

    // Two decoder beats make one window.
    uop_window_gather #(
        .LANES (LANES)
    ) gather_i (
        .w_fire01     (w_fire01),
        .rstn         (rstn),
        .i_drive      (i_drive),
        .i_uops       (i_uops),
        .i_free_next  (matrix_free),
        .o_free       (o_free),
        .o_drive_next (gather_drive),
        .o_uops       (gather_uops)
    );

    raw_match_matrix #(
        .LANES (LANES)
    ) matrix_i (
        .w_fire01     (w_fire01),
        .rstn         (rstn),
        .i_drive      (gather_drive),
        .i_uops       (gather_uops),
        .i_free_next  (encode_free),
        .o_free       (matrix_free),
        .o_drive_next (matrix_drive),
        .o_uops       (matrix_uops),
        .o_match_l    (match_l),
        .o_match_r    (match_r)
    );

    // Last stage faces the branch stage directly.
    nearest_producer_encode #(
        .LANES (LANES)
    ) encode_i (
        .w_fire01     (w_fire01),
        .rstn         (rstn),
        .i_drive      (matrix_drive),
        .i_uops       (matrix_uops),
        .i_match_l    (match_l),
        .i_match_r    (match_r),
        .i_free_next  (i_free_next),
        .o_free       (encode_free),
        .o_drive_next (o_drive),
        .o_uops       (o_uops),
        .o_dep_l      (o_dep_l),
        .o_dep_r      (o_dep_r)
    );

endmodule

/* design/dep_pkg.sv */
package dep_pkg;

    // Architectural register address width.
    localparam int REG_ADDR_W = 5;

    // Register address fields inside one uop.
    localparam int DEST_LSB = 0;                      // Destination register.
    localparam int SRCR_LSB = 5;                      // Right source register.
    localparam int SRCL_LSB = 10;                     // Left source register.

    // Valid flags that qualify the three address fields.
    localparam int DEST_VALID_BIT = 15;
    localparam int SRCR_VALID_BIT = 16;
    localparam int SRCL_VALID_BIT = 17;

    // Address fields and flags take the low bits, payload sits above them.
    localparam int FIELDS_W = 18;
    localparam int PAYLOAD_W = 6;                     // Opaque bits, carried untouched.

    localparam int UOP_W = FIELDS_W + PAYLOAD_W;

    // Which half of the window the next decoder beat fills.
    typedef enum logic {
        BEAT_LOW  = 1'b0,                             // Slots 0 to LANES-1.
        BEAT_HIGH = 1'b1                              // Slots LANES to WINDOW-1.
    } beat_e;

endpackage

/* design/dep_stage_ctrl.sv */
`timescale 1ns/1ns

module dep_stage_ctrl (
    input  logic w_fire01,
    input  logic rstn,
    input  logic i_free_next,
    input  logic i_drive,
    output logic o_free,
    output logic o_load,
    output logic o_drive_next
);

    logic r_full;

    // Room now, or the held item leaves on this edge.
    assign o_free = !r_full || i_free_next;
    assign o_load = i_drive && o_free;
    assign o_drive_next = r_full;

    always_ff @(posedge w_fire01 or negedge rstn) begin
        if (!rstn) begin
            r_full <= 1'b0;
        end else if (o_load) begin
            r_full <= 1'b1;                           // New item replaces any leaving one.
        end else if (i_free_next) begin
            r_full <= 1'b0;                           // Taken downstream, nothing new.
        end
    end

endmodule

/* design/nearest_producer_encode.sv */
`timescale 1ns/1ns

module nearest_producer_encode
    import dep_pkg::*;
#(
    parameter int LANES = 8
) (
    input  logic                                        w_fire01,
    input  logic                                        rstn,
    input  logic                                        i_drive,
    input  logic [2*LANES-1:0][UOP_W-1:0]               i_uops,
    input  logic [2*LANES-1:0][2*LANES-1:0]             i_match_l,
    input  logic [2*LANES-1:0][2*LANES-1:0]             i_match_r,
    input  logic                                        i_free_next,
    output logic                                        o_free,
    output logic                                        o_drive_next,
    output logic [2*LANES-1:0][UOP_W-1:0]               o_uops,
    output logic [2*LANES-1:0][$clog2(2*LANES)-1:0]     o_dep_l,
    output logic [2*LANES-1:0][$clog2(2*LANES)-1:0]     o_dep_r
);

    localparam int WINDOW = 2 * LANES;
    localparam int TAG_W = $clog2(WINDOW);
    localparam logic [TAG_W-1:0] TAG_NONE = {TAG_W{1'b1}};

    logic                           load;
    logic [WINDOW-1:0][TAG_W-1:0]   dep_l_d;
    logic [WINDOW-1:0][TAG_W-1:0]   dep_r_d;

    // Highest set column is the youngest older producer.
    function automatic logic [TAG_W-1:0] nearest_tag(input logic [WINDOW-1:0] row);
        logic [TAG_W-1:0] tag;
        tag = TAG_NONE;
        for (int k = 0; k < WINDOW; k++) begin
            if (row[k]) begin
                tag = TAG_W'(k);
            end
        end
        return tag;
    endfunction

    dep_stage_ctrl ctrl_i (
        .w_fire01     (w_fire01),
        .rstn         (rstn),
        .i_free_next  (i_free_next),
        .i_drive      (i_drive),
        .o_free       (o_free),
        .o_load       (load),
        .o_drive_next (o_drive_next)
    );

    always_comb begin
        for (int j = 0; j < WINDOW; j++) begin
            dep_l_d[j] = nearest_tag(i_match_l[j]);
            dep_r_d[j] = nearest_tag(i_match_r[j]);
        end
    end

    // Output stage, held while the branch stage stalls.
    always_ff @(posedge w_fire01 or negedge rstn) begin
        if (!rstn) begin
            o_uops <= '0;
            o_dep_l <= '0;
            o_dep_r <= '0;
        end else if (load) begin
            o_uops <= i_uops;
            o_dep_l <= dep_l_d;
            o_dep_r <= dep_r_d;
        end
    end

endmodule

/* design/raw_match_matrix.sv */
`timescale 1ns/1ns

module raw_match_matrix
    import dep_pkg::*;
#(
    parameter int LANES = 8
) (
    input  logic                                    w_fire01,
    input  logic                                    rstn,
    input  logic                                    i_drive,
    input  logic [2*LANES-1:0][UOP_W-1:0]           i_uops,
    input  logic                                    i_free_next,
    output logic                                    o_free,
    output logic                                    o_drive_next,
    output logic [2*LANES-1:0][UOP_W-1:0]           o_uops,
    output logic [2*LANES-1:0][2*LANES-1:0]         o_match_l,
    output logic [2*LANES-1:0][2*LANES-1:0]         o_match_r
);

    localparam int WINDOW = 2 * LANES;

    logic                           load;
    logic [WINDOW-1:0][WINDOW-1:0]  match_l_d;
    logic [WINDOW-1:0][WINDOW-1:0]  match_r_d;
    logic [WINDOW-1:0][UOP_W-1:0]   r_uops;
    logic [WINDOW-1:0][WINDOW-1:0]  r_match_l;
    logic [WINDOW-1:0][WINDOW-1:0]  r_match_r;

    dep_stage_ctrl ctrl_i (
        .w_fire01     (w_fire01),
        .rstn         (rstn),
        .i_free_next  (i_free_next),
        .i_drive      (i_drive),
        .o_free       (o_free),
        .o_load       (load),
        .o_drive_next (o_drive_next)
    );

    // Row j is the consumer, column k an older producer. Upper triangle stays zero.
    always_comb begin
        match_l_d = '0;
        match_r_d = '0;
        for (int j = 1; j < WINDOW; j++) begin
            for (int k = 0; k < j; k++) begin
                match_l_d[j][k] = i_uops[k][DEST_VALID_BIT]
                    && i_uops[j][SRCL_VALID_BIT]
                    && (i_uops[j][SRCL_LSB +: REG_ADDR_W] == i_uops[k][DEST_LSB +: REG_ADDR_W]);
                match_r_d[j][k] = i_uops[k][DEST_VALID_BIT]
                    && i_uops[j][SRCR_VALID_BIT]
                    && (i_uops[j][SRCR_LSB +: REG_ADDR_W] == i_uops[k][DEST_LSB +: REG_ADDR_W]);
            end
        end
    end

    always_ff @(posedge w_fire01 or negedge rstn) begin
        if (!rstn) begin
            r_uops <= '0;
            r_match_l <= '0;
            r_match_r <= '0;
        end else if (load) begin
            r_uops <= i_uops;                         // Window travels with its matrix.
            r_match_l <= match_l_d;
            r_match_r <= match_r_d;
        end
    end

    assign o_uops = r_uops;
    assign o_match_l = r_match_l;
    assign o_match_r = r_match_r;

endmodule

/* design/uop_window_gather.sv */
`timescale 1ns/1ns

module uop_window_gather
    import dep_pkg::*;
#(
    parameter int LANES = 8
) (
    input  logic                                w_fire01,
    input  logic                                rstn,
    input  logic                                i_drive,
    input  logic [LANES-1:0][UOP_W-1:0]         i_uops,
    input  logic                                i_free_next,
    output logic                                o_free,
    output logic                                o_drive_next,
    output logic [2*LANES-1:0][UOP_W-1:0]       o_uops
);

    localparam int WINDOW = 2 * LANES;

    beat_e                          r_beat;
    logic [WINDOW-1:0][UOP_W-1:0]   r_window;
    logic                           ctrl_free;
    logic                           high_drive;
    logic                           high_load;
    logic                           low_load;

    // Only the second beat completes a window.
    assign high_drive = i_drive && (r_beat == BEAT_HIGH);
    assign low_load = i_drive && ctrl_free && (r_beat == BEAT_LOW);

    dep_stage_ctrl ctrl_i (
        .w_fire01     (w_fire01),
        .rstn         (rstn),
        .i_free_next  (i_free_next),
        .i_drive      (high_drive),
        .o_free       (ctrl_free),
        .o_load       (high_load),
        .o_drive_next (o_drive_next)
    );

    // A low beat also waits for ctrl_free so a held window stays intact.
    assign o_free = ctrl_free;
    assign o_uops = r_window;

    always_ff @(posedge w_fire01 or negedge rstn) begin
        if (!rstn) begin
            r_beat <= BEAT_LOW;
        end else if (low_load || high_load) begin
            r_beat <= (r_beat == BEAT_LOW) ? BEAT_HIGH : BEAT_LOW;
        end
    end

    always_ff @(posedge w_fire01 or negedge rstn) begin
        if (!rstn) begin
            r_window <= '0;
        end else begin
            if (low_load) begin
                r_window[LANES-1:0] <= i_uops;        // Older beat.
            end
            if (high_load) begin
                r_window[WINDOW-1:LANES] <= i_uops;   // Younger beat.
            end
        end
    end

endmodule

/* filelist.f */
+incdir+tb
design/dep_pkg.sv
design/dep_stage_ctrl.sv
design/uop_window_gather.sv
design/raw_match_matrix.sv
design/nearest_producer_encode.sv
design/dep_check_top.sv
tb/tb_dep_check.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the dependency-check testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f filelist.f \
    --top-module tb_dep_check \
    -Mdir obj_dir

output=$(./obj_dir/Vtb_dep_check)
echo "$output"

if grep -qxF "TESTBENCH PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi

/* tb/dep_check_model.svh */
`ifndef DEP_CHECK_MODEL_SVH
`define DEP_CHECK_MODEL_SVH

// Slot k feeds slot j only when k is older, k writes a valid destination,
// j reads a valid source and both name the same register.

function automatic logic [REG_ADDR_W-1:0] dest_addr(input logic [UOP_W-1:0] uop);
    return uop[DEST_LSB +: REG_ADDR_W];
endfunction

function automatic logic dest_valid(input logic [UOP_W-1:0] uop);
    return uop[DEST_VALID_BIT];
endfunction

function automatic logic [REG_ADDR_W-1:0] src_addr(input logic [UOP_W-1:0] uop, input bit left);
    return left ? uop[SRCL_LSB +: REG_ADDR_W] : uop[SRCR_LSB +: REG_ADDR_W];
endfunction

function automatic logic src_valid(input logic [UOP_W-1:0] uop, input bit left);
    return left ? uop[SRCL_VALID_BIT] : uop[SRCR_VALID_BIT];
endfunction

function automatic bit feeds(input window_t win, input int k, input int j, input bit left);
    return dest_valid(win[k]) && src_valid(win[j], left)
        && (dest_addr(win[k]) == src_addr(win[j], left));
endfunction

function automatic logic [TAG_W-1:0] expected_tag(input window_t win, input int j, input bit left);
    logic [TAG_W-1:0] tag;
    bit               found;
    tag = TAG_NONE;
    found = 1'b0;
    // The first hit walking back from slot j-1 is the nearest producer.
    for (int k = j - 1; k >= 0; k--) begin
        if (!found && feeds(win, k, j, left)) begin
            tag = TAG_W'(k);
            found = 1'b1;
        end
    end
    return tag;
endfunction

function automatic int producer_count(input window_t win, input int j, input bit left);
    int count;
    count = 0;
    for (int k = 0; k < j; k++) begin
        if (feeds(win, k, j, left)) begin
            count++;
        end
    end
    return count;
endfunction

`endif

/* tb/tb_dep_check.sv */
`timescale 1ns/1ns

module tb_dep_check
    import dep_pkg::*;
();

    localparam int LANES = 8;
    localparam int WINDOW = 2 * LANES;
    localparam int TAG_W = $clog2(WINDOW);
    localparam logic [TAG_W-1:0] TAG_NONE = {TAG_W{1'b1}};
    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    localparam int unsigned SEED = 32'h2645_49bc;
    localparam int FREE_WINDOWS = 200;
    localparam int NEAR_WINDOWS = 100;
    localparam int VALID_WINDOWS = 100;
    localparam int STALL_WINDOWS = 200;
    localparam int STALL_BOUND = 8;                   // Cycles allowed per beat with stalls.
    localparam int TOTAL_BEATS = 2 * (FREE_WINDOWS + NEAR_WINDOWS + VALID_WINDOWS + STALL_WINDOWS);
    localparam int WATCHDOG_NS = (TOTAL_BEATS * STALL_BOUND + RESET_CYCLES) * CLK_PERIOD;

    typedef logic [LANES-1:0][UOP_W-1:0]  beat_t;
    typedef logic [WINDOW-1:0][UOP_W-1:0] window_t;
    typedef logic [WINDOW-1:0][TAG_W-1:0] tags_t;

    `include "dep_check_model.svh"

    logic    w_fire01;
    logic    rstn;
    logic    i_drive;
    beat_t   i_uops;
    logic    o_free;
    logic    o_drive;
    logic    i_free_next;
    window_t o_uops;
    tags_t   o_dep_l;
    tags_t   o_dep_r;

    beat_t       beat_q[$];
    window_t     exp_q[$];
    bit          stall_mode;
    bit          beat_taken;
    bit          held_valid;
    bit          saw_free_low;
    window_t     held_uops;
    tags_t       held_l;
    tags_t       held_r;
    string       cur_test;
    int          errors;
    int          test_err_base;
    int          out_count;
    int          out_base;
    int          multi_hits;
    int          tests_ok;
    int          tests_bad;

    dep_check_top #(
        .LANES (LANES)
    ) dut_i (
        .w_fire01    (w_fire01),
        .rstn        (rstn),
        .i_drive     (i_drive),
        .i_uops      (i_uops),
        .o_free      (o_free),
        .o_drive     (o_drive),
        .i_free_next (i_free_next),
        .o_uops      (o_uops),
        .o_dep_l     (o_dep_l),
        .o_dep_r     (o_dep_r)
    );

    initial begin
        w_fire01 = 1'b0;
        forever #(CLK_PERIOD / 2) w_fire01 = ~w_fire01;
    end

    // Decoder side and branch-stage free.
    always @(posedge w_fire01) begin
        if (rstn) begin
            beat_taken = i_drive && o_free;
            if (beat_taken) begin
                beat_q.delete(0);
            end
            // An offered beat stays until the gather stage takes it.
            if (!i_drive || beat_taken) begin
                if (beat_q.size() != 0 && !(stall_mode && $urandom_range(0, 3) == 0)) begin
                    i_drive <= 1'b1;
                    i_uops <= beat_q[0];
                end else begin
                    i_drive <= 1'b0;
                end
            end
            i_free_next <= stall_mode ? ($urandom_range(0, 2) != 0) : 1'b1;
        end
    end

    task automatic check_idle();
        assert (o_drive == 1'b0) else begin
            $display("[FAIL] %s o_drive: expected 0, actual %0d", cur_test, o_drive);
            errors++;
        end
        assert (o_free == 1'b1) else begin
            $display("[FAIL] %s o_free: expected 1, actual %0d", cur_test, o_free);
            errors++;
        end
    endtask

    task automatic check_window(input window_t exp);
        logic [TAG_W-1:0] exp_tag;
        logic [TAG_W-1:0] got_tag;
        bit               left;
        assert (o_uops == exp) else begin
            $display("[FAIL] %s window %0d o_uops: expected %h, actual %h",
                     cur_test, out_count, exp, o_uops);
            errors++;
        end
        for (int j = 0; j < WINDOW; j++) begin
            for (int side = 0; side < 2; side++) begin
                left = (side == 0);
                exp_tag = expected_tag(exp, j, left);
                got_tag = left ? o_dep_l[j] : o_dep_r[j];
                assert (got_tag == exp_tag) else begin
                    $display("[FAIL] %s window %0d slot %0d dep_%s: expected %0d, actual %0d",
                             cur_test, out_count, j, left ? "l" : "r", exp_tag, got_tag);
                    errors++;
                end
                if (got_tag != TAG_NONE) begin
                    assert (src_valid(exp[j], left) && dest_valid(exp[got_tag])) else begin
                        $display("[FAIL] %s window %0d slot %0d: tag %0d links an invalid reg",
                                 cur_test, out_count, j, got_tag);
                        errors++;
                    end
                end
            end
        end
    endtask

    task automatic check_hold();
        assert (o_drive) else begin
            $display("[FAIL] %s: o_drive fell while the branch stage was stalled", cur_test);
            errors++;
        end
        assert (o_uops == held_uops) else begin
            $display("[FAIL] %s hold o_uops: expected %h, actual %h", cur_test, held_uops, o_uops);
            errors++;
        end
        assert (o_dep_l == held_l && o_dep_r == held_r) else begin
            $display("[FAIL] %s hold o_dep_l/o_dep_r: expected %h/%h, actual %h/%h",
                     cur_test, held_l, held_r, o_dep_l, o_dep_r);
            errors++;
        end
    endtask

    // Output monitor.
    always @(posedge w_fire01) begin
        if (rstn) begin
            if (!o_free) begin
                saw_free_low = 1'b1;
            end
            if (held_valid) begin
                check_hold();
            end
            if (o_drive && i_free_next) begin
                assert (exp_q.size() != 0) else begin
                    $display("[FAIL] %s: a window came out that was never sent", cur_test);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    check_window(exp_q[0]);
                    exp_q.delete(0);
                    out_count++;
                end
            end
            held_valid = o_drive && !i_free_next;
            held_uops = o_uops;
            held_l = o_dep_l;
            held_r = o_dep_r;
        end
    end

    function automatic logic [UOP_W-1:0] make_uop(input int addr_max, input bit random_valid);
        logic [UOP_W-1:0] uop;
        uop = UOP_W'($urandom());                     // Payload stays random.
        uop[DEST_LSB +: REG_ADDR_W] = REG_ADDR_W'($urandom_range(0, addr_max));
        uop[SRCR_LSB +: REG_ADDR_W] = REG_ADDR_W'($urandom_range(0, addr_max));
        uop[SRCL_LSB +: REG_ADDR_W] = REG_ADDR_W'($urandom_range(0, addr_max));
        uop[DEST_VALID_BIT] = random_valid ? ($urandom_range(0, 3) != 0) : 1'b1;
        uop[SRCR_VALID_BIT] = random_valid ? ($urandom_range(0, 3) != 0) : 1'b1;
        uop[SRCL_VALID_BIT] = random_valid ? ($urandom_range(0, 3) != 0) : 1'b1;
        return uop;
    endfunction

    task automatic queue_window(input int addr_max, input bit random_valid);
        window_t win;
        for (int s = 0; s < WINDOW; s++) begin
            win[s] = make_uop(addr_max, random_valid);
        end
        for (int j = 0; j < WINDOW; j++) begin
            if (producer_count(win, j, 1'b1) > 1 || producer_count(win, j, 1'b0) > 1) begin
                multi_hits++;
            end
        end
        beat_q.push_back(win[LANES-1:0]);             // Older beat first.
        beat_q.push_back(win[WINDOW-1:LANES]);
        exp_q.push_back(win);
    endtask

    task automatic run_test(input string name, input int windows, input int addr_max,
                            input bit random_valid, input bit stall);
        cur_test = name;
        test_err_base = errors;
        out_base = out_count;
        stall_mode = stall;
        for (int i = 0; i < windows; i++) begin
            queue_window(addr_max, random_valid);
        end
        while (exp_q.size() != 0) begin
            @(posedge w_fire01);
        end
    endtask

    task automatic report_test();
        if (errors == test_err_base) begin
            tests_ok++;
            $display("Test %s ok, %0d windows", cur_test, out_count - out_base);
        end else begin
            tests_bad++;
            $display("Test %s %0d errors, %0d windows", cur_test,
                     errors - test_err_base, out_count - out_base);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rstn = 1'b0;
        i_drive = 1'b0;
        i_uops = '0;
        i_free_next = 1'b1;
        cur_test = "reset";
        repeat (RESET_CYCLES) begin
            @(posedge w_fire01);
            check_idle();
        end
        rstn <= 1'b1;
        @(posedge w_fire01);
        check_idle();
        report_test();
        run_test("free_flow", FREE_WINDOWS, 7, 1'b0, 1'b0);
        report_test();
        multi_hits = 0;
        run_test("nearest_producer", NEAR_WINDOWS, 1, 1'b0, 1'b0);
        assert (multi_hits > 0) else begin
            $display("[FAIL] nearest_producer: no slot ever had two candidate producers");
            errors++;
        end
        report_test();
        run_test("valid_flags", VALID_WINDOWS, 3, 1'b1, 1'b0);
        report_test();
        saw_free_low = 1'b0;
        run_test("back_pressure", STALL_WINDOWS, 3, 1'b1, 1'b1);
        assert (saw_free_low) else begin
            $display("[FAIL] back_pressure: o_free never fell, the stall never reached the input");
            errors++;
        end
        report_test();
        $display("Summary: %0d tests ok, %0d tests with errors, %0d windows, %0d errors",
                 tests_ok, tests_bad, out_count, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout in test %s: the windows did not drain in %0d ns", cur_test, WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
